/* hdl/mcu_ao_consts.svh */
// ==============================
// mcu_ao constants
// widths, interrupt bit positions and register offsets
// ==============================

`ifndef MCU_AO_CONSTS_SVH
`define MCU_AO_CONSTS_SVH

`define MCU_DATA_W      32
`define MCU_ADDR_W      8
`define NUM_FAST_IRQ    15
`define NUM_TIMER_IRQ   4
`define NUM_GPIO_AO_IRQ 8

`define IRQ_SW_BIT    3
`define IRQ_TIMER_BIT 7
`define IRQ_EXT_BIT   11
`define IRQ_FAST_LSB  16

`define REG_IRQ_EN   8'h00
`define REG_IRQ_PEND 8'h04
`define REG_PWR_CTRL 8'h08
`define REG_PWR_STAT 8'h0C
`define REG_EXIT     8'h10

`endif

/* hdl/mcu_ao_pkg.sv */
// ==============================
// mcu_ao_pkg: shared types of the always-on control slice
// ==============================

`include "mcu_ao_consts.svh"

package mcu_ao_pkg;

  typedef logic [`MCU_DATA_W-1:0]   mcu_word_t;
  typedef logic [`MCU_ADDR_W-1:0]   mcu_addr_t;
  typedef logic [`MCU_DATA_W-1:0]   irq_vec_t;
  typedef logic [`NUM_FAST_IRQ-1:0] fast_irq_t;

  // raw interrupt sources before placement in the vector
  typedef struct packed {
    logic                          irq_software;
    logic                          irq_external;
    logic [`NUM_TIMER_IRQ-1:0]     timer;
    logic [`NUM_GPIO_AO_IRQ-1:0]   gpio_ao;
    logic                          spi_flash;
    logic                          spi;
    logic                          dma_done;
  } irq_src_t;

  // obi style request and response
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [`MCU_DATA_W/8-1:0]  be;
    mcu_addr_t                 addr;
    mcu_word_t                 wdata;
  } bus_req_t;

  typedef struct packed {
    logic      gnt;
    logic      rvalid;
    mcu_word_t rdata;
  } bus_rsp_t;

  // all active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
  } pwr_ctrl_t;

  typedef enum logic [2:0] {
    PD_ON,
    PD_ISO_ON,
    PD_RST_ON,
    PD_SW_OFF,
    PD_OFF,
    PD_SW_ON,
    PD_RST_OFF,
    PD_ISO_OFF
  } pd_state_e;

endpackage

/* hdl/irq_aggregator.sv */
// ==============================
// irq_aggregator: builds the core interrupt vector
// and raises wake on any enabled pending bit
// ==============================

`include "mcu_ao_consts.svh"

module irq_aggregator (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mcu_ao_pkg::irq_src_t  src_i,
  input  mcu_ao_pkg::irq_vec_t  irq_en_i,
  output mcu_ao_pkg::irq_vec_t  irq_o,
  output logic                  wake_o
);

  import mcu_ao_pkg::*;

  fast_irq_t fast_irq;
  irq_vec_t  irq_d;
  irq_vec_t  irq_q;

  // top fast line is unused, as on the full chip
  always_comb begin
    fast_irq = {
      1'b0,
      src_i.gpio_ao,
      src_i.spi_flash,
      src_i.spi,
      src_i.dma_done,
      src_i.timer[`NUM_TIMER_IRQ-1:1]
    };
  end

  // standard risc-v positions plus the fast group
  always_comb begin
    irq_d = '0;
    irq_d[`IRQ_SW_BIT] = src_i.irq_software;
    irq_d[`IRQ_TIMER_BIT] = src_i.timer[0];
    irq_d[`IRQ_EXT_BIT] = src_i.irq_external;
    irq_d[`IRQ_FAST_LSB +: `NUM_FAST_IRQ] = fast_irq;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o = irq_q;

  // wake works on the registered vector
  assign wake_o = |(irq_q & irq_en_i);

endmodule

/* hdl/power_domain_seq.sv */
// ==============================
// power_domain_seq: ordered power-off and power-on
// of one switchable domain
// ==============================

module power_domain_seq (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   off_req_i,
  input  logic                   pwr_ack_n_i,
  output mcu_ao_pkg::pwr_ctrl_t  pwr_o,
  output logic                   on_o
);

  import mcu_ao_pkg::*;

  pd_state_e state_q;
  pd_state_e state_d;
  pwr_ctrl_t pwr_q;

  // control levels seen in each state
  function automatic pwr_ctrl_t pd_ctrl(pd_state_e st);
    pwr_ctrl_t c;
    c.pwrgate_en_n = 1'b0;
    c.isogate_en_n = 1'b1;
    c.rst_n        = 1'b1;
    c.clkgate_en_n = 1'b1;
    case (st)
      PD_ISO_ON, PD_RST_OFF: begin
        c.isogate_en_n = 1'b0;
      end
      PD_RST_ON, PD_SW_ON: begin
        c.isogate_en_n = 1'b0;
        c.rst_n        = 1'b0;
        c.clkgate_en_n = 1'b0;
      end
      PD_SW_OFF, PD_OFF: begin
        c.pwrgate_en_n = 1'b1;
        c.isogate_en_n = 1'b0;
        c.rst_n        = 1'b0;
        c.clkgate_en_n = 1'b0;
      end
      default: begin
        c.pwrgate_en_n = 1'b0;
      end
    endcase
    return c;
  endfunction

  always_comb begin
    state_d = state_q;
    case (state_q)
      PD_ON: begin
        if (off_req_i) begin
          state_d = PD_ISO_ON;
        end
      end
      PD_ISO_ON:  state_d = PD_RST_ON;
      PD_RST_ON:  state_d = PD_SW_OFF;
      // switch opened, wait for the rail to drop
      PD_SW_OFF: begin
        if (pwr_ack_n_i) begin
          state_d = PD_OFF;
        end
      end
      PD_OFF: begin
        if (!off_req_i) begin
          state_d = PD_SW_ON;
        end
      end
      PD_SW_ON: begin
        if (!pwr_ack_n_i) begin
          state_d = PD_RST_OFF;
        end
      end
      PD_RST_OFF: state_d = PD_ISO_OFF;
      PD_ISO_OFF: state_d = PD_ON;
      default:    state_d = PD_ON;
    endcase
  end

  // outputs registered with the state to keep them glitch free
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= PD_ON;
      pwr_q   <= pd_ctrl(PD_ON);
    end else begin
      state_q <= state_d;
      pwr_q   <= pd_ctrl(state_d);
    end
  end

  assign pwr_o = pwr_q;
  assign on_o  = (state_q == PD_ON);

endmodule

/* hdl/mcu_ao_regs.sv */
// ==============================
// mcu_ao_regs: bus slave with interrupt enable,
// power request, power status and exit registers
// ==============================

`include "mcu_ao_consts.svh"

module mcu_ao_regs (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mcu_ao_pkg::bus_req_t  bus_req_i,
  output mcu_ao_pkg::bus_rsp_t  bus_rsp_o,
  input  mcu_ao_pkg::irq_vec_t  irq_vec_i,
  input  logic                  wake_i,
  input  logic                  cpu_on_i,
  input  logic                  periph_on_i,
  input  logic                  core_sleep_i,
  output mcu_ao_pkg::irq_vec_t  irq_en_o,
  output logic                  cpu_off_req_o,
  output logic                  periph_off_req_o,
  output logic                  exit_valid_o,
  output mcu_ao_pkg::mcu_word_t exit_value_o
);

  import mcu_ao_pkg::*;

  irq_vec_t  irq_en_q;
  logic      sleep_q;
  logic      periph_off_q;
  logic      exit_valid_q;
  mcu_word_t exit_value_q;
  logic      rvalid_q;
  mcu_word_t rdata_q;
  mcu_word_t rdata_d;
  logic      wr_en;
  logic      rd_en;

  function automatic mcu_word_t merge_bytes(mcu_word_t old_w, mcu_word_t new_w,
                                            logic [`MCU_DATA_W/8-1:0] be);
    mcu_word_t res;
    res = old_w;
    for (int i = 0; i < `MCU_DATA_W / 8; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  // every request is granted at once
  assign wr_en = bus_req_i.req & bus_req_i.we;
  assign rd_en = bus_req_i.req & ~bus_req_i.we;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_en_q     <= '0;
      sleep_q      <= 1'b0;
      periph_off_q <= 1'b0;
      exit_valid_q <= 1'b0;
    end else begin
      if (wr_en && bus_req_i.addr == `REG_IRQ_EN) begin
        irq_en_q <= merge_bytes(irq_en_q, bus_req_i.wdata, bus_req_i.be);
      end
      if (wr_en && bus_req_i.addr == `REG_PWR_CTRL && bus_req_i.be[0]) begin
        sleep_q      <= bus_req_i.wdata[0];
        periph_off_q <= bus_req_i.wdata[1];
      end
      // a pending enabled interrupt cancels the sleep request
      if (wake_i) begin
        sleep_q <= 1'b0;
      end
      if (wr_en && bus_req_i.addr == `REG_EXIT) begin
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && bus_req_i.addr == `REG_EXIT) begin
      exit_value_q <= merge_bytes(exit_value_q, bus_req_i.wdata, bus_req_i.be);
    end
  end

  // read mux, unmapped offsets read zero
  always_comb begin
    rdata_d = '0;
    case (bus_req_i.addr)
      `REG_IRQ_EN:   rdata_d = irq_en_q;
      `REG_IRQ_PEND: rdata_d = irq_vec_i;
      `REG_PWR_CTRL: rdata_d = {{(`MCU_DATA_W-2){1'b0}}, periph_off_q, sleep_q};
      `REG_PWR_STAT: rdata_d = {{(`MCU_DATA_W-2){1'b0}}, periph_on_i, cpu_on_i};
      `REG_EXIT:     rdata_d = exit_value_q;
      default:       rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
    end
  end

  // write responses carry zero data
  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      rdata_q <= rd_en ? rdata_d : '0;
    end
  end

  assign bus_rsp_o.gnt    = bus_req_i.req;
  assign bus_rsp_o.rvalid = rvalid_q;
  assign bus_rsp_o.rdata  = rdata_q;

  assign irq_en_o         = irq_en_q;
  assign cpu_off_req_o    = sleep_q & core_sleep_i;
  assign periph_off_req_o = periph_off_q;
  assign exit_valid_o     = exit_valid_q;
  assign exit_value_o     = exit_value_q;

endmodule

/* hdl/mcu_ao_top.sv */
// ==============================
// mcu_ao_top: always-on control slice with interrupt
// aggregation, two domain sequencers and registers
// ==============================

module mcu_ao_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mcu_ao_pkg::bus_req_t  bus_req_i,
  output mcu_ao_pkg::bus_rsp_t  bus_rsp_o,
  input  mcu_ao_pkg::irq_src_t  irq_src_i,
  input  logic                  core_sleep_i,
  input  logic                  cpu_pwr_ack_n_i,
  input  logic                  periph_pwr_ack_n_i,
  output mcu_ao_pkg::pwr_ctrl_t cpu_pwr_o,
  output mcu_ao_pkg::pwr_ctrl_t periph_pwr_o,
  output mcu_ao_pkg::irq_vec_t  irq_o,
  output logic                  exit_valid_o,
  output mcu_ao_pkg::mcu_word_t exit_value_o
);

  import mcu_ao_pkg::*;

  irq_vec_t irq_en;
  logic     wake;
  logic     cpu_off_req;
  logic     periph_off_req;
  logic     cpu_on;
  logic     periph_on;

  irq_aggregator irq_agg (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .src_i    (irq_src_i),
    .irq_en_i (irq_en),
    .irq_o    (irq_o),
    .wake_o   (wake)
  );

  // cpu domain follows the sleep request
  power_domain_seq cpu_seq (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .off_req_i   (cpu_off_req),
    .pwr_ack_n_i (cpu_pwr_ack_n_i),
    .pwr_o       (cpu_pwr_o),
    .on_o        (cpu_on)
  );

  power_domain_seq periph_seq (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .off_req_i   (periph_off_req),
    .pwr_ack_n_i (periph_pwr_ack_n_i),
    .pwr_o       (periph_pwr_o),
    .on_o        (periph_on)
  );

  mcu_ao_regs regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .bus_req_i        (bus_req_i),
    .bus_rsp_o        (bus_rsp_o),
    .irq_vec_i        (irq_o),
    .wake_i           (wake),
    .cpu_on_i         (cpu_on),
    .periph_on_i      (periph_on),
    .core_sleep_i     (core_sleep_i),
    .irq_en_o         (irq_en),
    .cpu_off_req_o    (cpu_off_req),
    .periph_off_req_o (periph_off_req),
    .exit_valid_o     (exit_valid_o),
    .exit_value_o     (exit_value_o)
  );

endmodule

/* dv/mcu_ao_assertions.sv */
// ==============================
// mcu_ao_assertions: bus, interrupt map, power order
// and exit register properties
// ==============================

`include "mcu_ao_consts.svh"

module mcu_ao_assertions (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input mcu_ao_pkg::bus_req_t  bus_req_i,
  input mcu_ao_pkg::bus_rsp_t  bus_rsp_o,
  input mcu_ao_pkg::irq_src_t  irq_src_i,
  input mcu_ao_pkg::irq_vec_t  irq_o,
  input mcu_ao_pkg::pwr_ctrl_t cpu_pwr_o,
  input mcu_ao_pkg::pwr_ctrl_t periph_pwr_o,
  input logic                  exit_valid_o,
  input mcu_ao_pkg::mcu_word_t exit_value_o
);

  import mcu_ao_pkg::*;

  int fail_cnt = 0;

  // expected vector built straight from the source layout
  function automatic irq_vec_t expected_irq(irq_src_t s);
    irq_vec_t v;
    v = '0;
    v[3]  = s.irq_software;
    v[7]  = s.timer[0];
    v[11] = s.irq_external;
    v[16] = s.timer[1];
    v[17] = s.timer[2];
    v[18] = s.timer[3];
    v[19] = s.dma_done;
    v[20] = s.spi;
    v[21] = s.spi_flash;
    v[29:22] = s.gpio_ao;
    return v;
  endfunction

  gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_rsp_o.gnt == bus_req_i.req)
    else begin fail_cnt++; $error("gnt does not follow req"); end

  rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_req_i.req |=> bus_rsp_o.rvalid)
    else begin fail_cnt++; $error("rvalid missing after request"); end

  no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !bus_req_i.req |=> !bus_rsp_o.rvalid)
    else begin fail_cnt++; $error("rvalid without request"); end

  irq_map: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $changed(irq_src_i) |=> irq_o == expected_irq($past(irq_src_i)))
    else begin fail_cnt++; $error("interrupt vector layout mismatch"); end

  // isolation before reset, reset before switch, reverse on the way up
  cpu_iso_before_rst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(cpu_pwr_o.rst_n) |-> $past(!cpu_pwr_o.isogate_en_n))
    else begin fail_cnt++; $error("cpu reset before isolation"); end

  cpu_rst_before_sw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cpu_pwr_o.pwrgate_en_n) |-> $past(!cpu_pwr_o.rst_n))
    else begin fail_cnt++; $error("cpu switch off before reset"); end

  cpu_sw_before_rst_rel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cpu_pwr_o.rst_n) |-> $past(!cpu_pwr_o.pwrgate_en_n) && !cpu_pwr_o.isogate_en_n)
    else begin fail_cnt++; $error("cpu reset released out of order"); end

  per_iso_before_rst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(periph_pwr_o.rst_n) |-> $past(!periph_pwr_o.isogate_en_n))
    else begin fail_cnt++; $error("periph reset before isolation"); end

  per_rst_before_sw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(periph_pwr_o.pwrgate_en_n) |-> $past(!periph_pwr_o.rst_n))
    else begin fail_cnt++; $error("periph switch off before reset"); end

  per_sw_before_rst_rel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(periph_pwr_o.rst_n) |-> $past(!periph_pwr_o.pwrgate_en_n)
      && !periph_pwr_o.isogate_en_n)
    else begin fail_cnt++; $error("periph reset released out of order"); end

  exit_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_req_i.req && bus_req_i.we && bus_req_i.addr == `REG_EXIT && bus_req_i.be == 4'hf
      |=> exit_valid_o && exit_value_o == $past(bus_req_i.wdata))
    else begin fail_cnt++; $error("exit register not updated"); end

  exit_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exit_valid_o |=> exit_valid_o)
    else begin fail_cnt++; $error("exit valid dropped"); end

endmodule

bind mcu_ao_top mcu_ao_assertions asrt (.*);

/* dv/mcu_ao_tb.sv */
// ==============================
// mcu_ao_tb: testbench for the always-on control slice
// ==============================

`include "mcu_ao_consts.svh"

module mcu_ao_tb;

  import mcu_ao_pkg::*;

  // covers all phases with ack delays at their longest
  localparam int TIMEOUT_CYCLES = 3000;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  bus_req_t  bus_req;
  bus_rsp_t  bus_rsp;
  irq_src_t  irq_src;
  logic      core_sleep;
  logic      cpu_ack_n;
  logic      periph_ack_n;
  pwr_ctrl_t cpu_pwr;
  pwr_ctrl_t periph_pwr;
  irq_vec_t  irq_vec;
  logic      exit_valid;
  mcu_word_t exit_value;
  integer    seed = 32'hf6f2576e;
  int        err_cnt = 0;

  mcu_ao_top uut (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .bus_req_i          (bus_req),
    .bus_rsp_o          (bus_rsp),
    .irq_src_i          (irq_src),
    .core_sleep_i       (core_sleep),
    .cpu_pwr_ack_n_i    (cpu_ack_n),
    .periph_pwr_ack_n_i (periph_ack_n),
    .cpu_pwr_o          (cpu_pwr),
    .periph_pwr_o       (periph_pwr),
    .irq_o              (irq_vec),
    .exit_valid_o       (exit_valid),
    .exit_value_o       (exit_value)
  );

  always #20 clk_i = ~clk_i;

  // switch model, ack follows the gate after 1 to 8 cycles
  always begin : cpu_switch_model
    int dly;
    @(negedge clk_i);
    if (cpu_ack_n != cpu_pwr.pwrgate_en_n) begin
      dly = 1 + ($unsigned($random(seed)) % 8);
      repeat (dly) @(negedge clk_i);
      cpu_ack_n = cpu_pwr.pwrgate_en_n;
    end
  end

  always begin : periph_switch_model
    int dly;
    @(negedge clk_i);
    if (periph_ack_n != periph_pwr.pwrgate_en_n) begin
      dly = 1 + ($unsigned($random(seed)) % 8);
      repeat (dly) @(negedge clk_i);
      periph_ack_n = periph_pwr.pwrgate_en_n;
    end
  end

  function automatic irq_vec_t build_irq_vec(irq_src_t s);
    irq_vec_t v;
    v = '0;
    v[3]  = s.irq_software;
    v[7]  = s.timer[0];
    v[11] = s.irq_external;
    v[18:16] = s.timer[3:1];
    v[19] = s.dma_done;
    v[20] = s.spi;
    v[21] = s.spi_flash;
    v[29:22] = s.gpio_ao;
    return v;
  endfunction

  task automatic bus_write(input mcu_addr_t addr, input mcu_word_t data);
    bus_req = '{req: 1'b1, we: 1'b1, be: 4'hf, addr: addr, wdata: data};
    @(negedge clk_i);
    bus_req = '0;
    @(negedge clk_i);
  endtask

  // data sampled on the falling edge while rvalid is high
  task automatic bus_read(input mcu_addr_t addr, output mcu_word_t data);
    bus_req = '{req: 1'b1, we: 1'b0, be: 4'hf, addr: addr, wdata: '0};
    @(negedge clk_i);
    bus_req = '0;
    data = bus_rsp.rdata;
  endtask

  task automatic compare(input string name, input mcu_word_t exp, input mcu_word_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic read_check(input string name, input mcu_addr_t addr, input mcu_word_t exp);
    mcu_word_t rd;
    bus_read(addr, rd);
    compare(name, exp, rd);
  endtask

  task automatic wait_stat(input mcu_word_t mask, input mcu_word_t value);
    mcu_word_t rd;
    bus_read(`REG_PWR_STAT, rd);
    while ((rd & mask) != value) begin
      bus_read(`REG_PWR_STAT, rd);
    end
  endtask

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : stimulus
    irq_src_t src;
    rst_n_i = 1'b0;
    bus_req = '0;
    irq_src = '0;
    core_sleep = 1'b0;
    cpu_ack_n = 1'b0;
    periph_ack_n = 1'b0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    compare("reset_cpu_pwr", 32'h7, cpu_pwr);
    compare("reset_periph_pwr", 32'h7, periph_pwr);
    compare("reset_exit_valid", 32'h0, exit_valid);
    read_check("reset_pwr_stat", `REG_PWR_STAT, 32'h3);

    for (int i = 0; i < 20; i++) begin
      src = $random(seed);
      irq_src = src;
      @(negedge clk_i);
      read_check("irq_map", `REG_IRQ_PEND, build_irq_vec(src));
    end
    irq_src = '0;
    @(negedge clk_i);

    // peripheral domain off and back on
    bus_write(`REG_PWR_CTRL, 32'h2);
    wait_stat(32'h2, 32'h0);
    // power-off completes with the switch ack
    while (periph_ack_n !== 1'b1) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    compare("periph_off_pwr", 32'h8, periph_pwr);
    read_check("periph_off_stat", `REG_PWR_STAT, 32'h1);
    bus_write(`REG_PWR_CTRL, 32'h0);
    wait_stat(32'h3, 32'h3);
    compare("periph_on_pwr", 32'h7, periph_pwr);

    // cpu sleep, wake only on the enabled software line
    bus_write(`REG_IRQ_EN, 32'h8);
    bus_write(`REG_PWR_CTRL, 32'h1);
    core_sleep = 1'b1;
    wait_stat(32'h1, 32'h0);
    irq_src.irq_external = 1'b1;
    repeat (20) @(negedge clk_i);
    read_check("disabled_src_stat", `REG_PWR_STAT, 32'h2);
    read_check("disabled_src_ctrl", `REG_PWR_CTRL, 32'h1);
    irq_src.irq_external = 1'b0;
    irq_src.irq_software = 1'b1;
    wait_stat(32'h3, 32'h3);
    read_check("wake_ctrl", `REG_PWR_CTRL, 32'h0);
    core_sleep = 1'b0;
    irq_src = '0;
    @(negedge clk_i);

    bus_write(`REG_EXIT, 32'hc0de1234);
    compare("exit_valid", 32'h1, exit_valid);
    compare("exit_value", 32'hc0de1234, exit_value);
    read_check("exit_read", `REG_EXIT, 32'hc0de1234);
    read_check("unmapped_read", 8'h40, 32'h0);
    repeat (4) @(negedge clk_i);

    $display("errors: read checks %0d, assertions %0d", err_cnt, uut.asrt.fail_cnt);
    if (err_cnt == 0 && uut.asrt.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* mcu_ao_top.f */
+incdir+hdl
hdl/mcu_ao_pkg.sv
hdl/irq_aggregator.sv
hdl/power_domain_seq.sv
hdl/mcu_ao_regs.sv
hdl/mcu_ao_top.sv
dv/mcu_ao_assertions.sv
dv/mcu_ao_tb.sv
